//--- common/mipsPkg.sv
/* mipsPkg
   encodings and stage-register layouts shared by the pipelined MIPS core */
package mipsPkg;
	localparam int dataWidth = 32;   // word size
	localparam int regAddrWidth = 5; // 32 architectural registers

	// opcodes in instr[31:26]
	localparam logic [5:0] opRtype = 6'b000000;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opSw = 6'b101011;
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opJ = 6'b000010;

	// funct field for r-type
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnSlt = 6'b101010;

	// alu operation select
	localparam logic [2:0] aluCtlAnd = 3'b000;
	localparam logic [2:0] aluCtlOr = 3'b001;
	localparam logic [2:0] aluCtlAdd = 3'b010;
	localparam logic [2:0] aluCtlSub = 3'b110;
	localparam logic [2:0] aluCtlSlt = 3'b111;

	typedef enum logic [1:0] {
		aluOpAdd = 2'b00,  // lw, sw, addi
		aluOpSub = 2'b01,  // beq
		aluOpFunct = 2'b10 // r-type, look at funct
	} aluOpT;

	// fetch -> decode
	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] pcPlus4;
	} ifIdT;

	// decode -> execute
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic [2:0] aluControl;
		logic [dataWidth-1:0] rd1;
		logic [dataWidth-1:0] rd2;
		logic [dataWidth-1:0] signImm;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
	} idExT;

	// execute -> memory
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] writeData;
		logic [regAddrWidth-1:0] writeReg;
	} exMemT;

	// memory -> writeback
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [dataWidth-1:0] readData;
		logic [dataWidth-1:0] aluOut;
		logic [regAddrWidth-1:0] writeReg;
	} memWbT;
endpackage

//--- source/alu.sv
/* alu
   and, or, add, sub and signed set-less-than */
`timescale 1ns/1ps

module alu (
	input  logic [mipsPkg::dataWidth-1:0] a,
	input  logic [mipsPkg::dataWidth-1:0] b,
	input  logic [2:0]                    aluControl,
	output logic [mipsPkg::dataWidth-1:0] result
);
	always_comb begin
		case (aluControl)
			mipsPkg::aluCtlAnd: result = a & b;
			mipsPkg::aluCtlOr: result = a | b;
			mipsPkg::aluCtlAdd: result = a + b;
			mipsPkg::aluCtlSub: result = a - b;
			mipsPkg::aluCtlSlt: begin
				result = '0;
				result[0] = $signed(a) < $signed(b); // signed compare
			end
			default: result = '0; // unused codes
		endcase
	end
endmodule

//--- source/regFile.sv
/* regFile
   32x32 registers, two async reads, write on falling clock edge */
`timescale 1ns/1ps

module regFile (
	input  logic                               clk,
	input  logic                               arstN,
	input  logic                               we,
	input  logic [mipsPkg::regAddrWidth-1:0]   ra1,
	input  logic [mipsPkg::regAddrWidth-1:0]   ra2,
	input  logic [mipsPkg::regAddrWidth-1:0]   wa,
	input  logic [mipsPkg::dataWidth-1:0]      wd,
	output logic [mipsPkg::dataWidth-1:0]      rd1,
	output logic [mipsPkg::dataWidth-1:0]      rd2
);
	logic [mipsPkg::dataWidth-1:0] rf [2**mipsPkg::regAddrWidth];

	// negedge write so decode sees writeback data within the same cycle
	always_ff @(negedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++) begin
				rf[i] <= '0;
			end
		end else if (we && wa != '0) begin
			rf[wa] <= wd;
		end
	end

	// $0 hardwired
	assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
	assign rd2 = (ra2 == '0) ? '0 : rf[ra2];
endmodule

//--- source/pipeReg.sv
/* pipeReg
   pipeline stage register, clear inserts a bubble, enable low holds */
`timescale 1ns/1ps

module pipeReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    arstN,
	input  logic    en,  // low while stalled
	input  logic    clr, // flush, wins over en
	input  payloadT d,
	output payloadT q
);
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (clr) begin
			q <= '0; // all-zero payload is a nop
		end else if (en) begin
			q <= d;
		end
	end
endmodule

//--- source/controller.sv
/* controller
   decode-stage control, main decoder plus alu decoder */
`timescale 1ns/1ps

module controller (
	input  logic [5:0] op,
	input  logic [5:0] funct,
	input  logic       equalD,      // forwarded operands match
	output logic       branchD,
	output logic       pcSrcD,      // taken beq
	output logic       jumpD,
	output logic       regWriteD,
	output logic       memToRegD,
	output logic       memWriteD,
	output logic       regDstD,
	output logic       aluSrcD,
	output logic [2:0] aluControlD
);
	mipsPkg::aluOpT aluOp;

	mainDec uMainDec (.op(op), .regWriteD(regWriteD), .regDstD(regDstD), .aluSrcD(aluSrcD),
		.branchD(branchD), .memWriteD(memWriteD), .memToRegD(memToRegD), .jumpD(jumpD),
		.aluOp(aluOp));

	aluDec uAluDec (.funct(funct), .aluOp(aluOp), .aluControlD(aluControlD));

	assign pcSrcD = branchD & equalD; // branch resolved here in decode
endmodule

module mainDec (
	input  logic [5:0]     op,
	output logic           regWriteD,
	output logic           regDstD,
	output logic           aluSrcD,
	output logic           branchD,
	output logic           memWriteD,
	output logic           memToRegD,
	output logic           jumpD,
	output mipsPkg::aluOpT aluOp
);
	logic [6:0] ctl; // regWrite regDst aluSrc branch memWrite memToReg jump

	assign {regWriteD, regDstD, aluSrcD, branchD, memWriteD, memToRegD, jumpD} = ctl;

	always_comb begin
		ctl = '0;                 // unknown op becomes a bubble
		aluOp = mipsPkg::aluOpAdd;
		case (op)
			mipsPkg::opRtype: begin
				ctl = 7'b1100000;
				aluOp = mipsPkg::aluOpFunct;
			end
			mipsPkg::opLw: ctl = 7'b1010010;
			mipsPkg::opSw: ctl = 7'b0010100;
			mipsPkg::opBeq: begin
				ctl = 7'b0001000;
				aluOp = mipsPkg::aluOpSub;
			end
			mipsPkg::opAddi: ctl = 7'b1010000;
			mipsPkg::opJ: ctl = 7'b0000001;
			default: ctl = '0;
		endcase
	end
endmodule

module aluDec (
	input  logic [5:0]     funct,
	input  mipsPkg::aluOpT aluOp,
	output logic [2:0]     aluControlD
);
	always_comb begin
		case (aluOp)
			mipsPkg::aluOpAdd: aluControlD = mipsPkg::aluCtlAdd; // address / immediate
			mipsPkg::aluOpSub: aluControlD = mipsPkg::aluCtlSub;
			default: begin
				case (funct)
					mipsPkg::fnSub: aluControlD = mipsPkg::aluCtlSub;
					mipsPkg::fnAnd: aluControlD = mipsPkg::aluCtlAnd;
					mipsPkg::fnOr: aluControlD = mipsPkg::aluCtlOr;
					mipsPkg::fnSlt: aluControlD = mipsPkg::aluCtlSlt;
					default: aluControlD = mipsPkg::aluCtlAdd; // fnAdd and anything odd
				endcase
			end
		endcase
	end
endmodule

//--- datapath/hazardUnit.sv
/* hazardUnit
   forwarding selects, load-use and branch stalls, decode and execute flushes */
`timescale 1ns/1ps

module hazardUnit (
	input  logic [mipsPkg::regAddrWidth-1:0] rsD,
	input  logic [mipsPkg::regAddrWidth-1:0] rtD,
	input  logic [mipsPkg::regAddrWidth-1:0] rsE,
	input  logic [mipsPkg::regAddrWidth-1:0] rtE,
	input  logic [mipsPkg::regAddrWidth-1:0] writeRegE,
	input  logic [mipsPkg::regAddrWidth-1:0] writeRegM,
	input  logic [mipsPkg::regAddrWidth-1:0] writeRegW,
	input  logic                             regWriteE,
	input  logic                             regWriteM,
	input  logic                             regWriteW,
	input  logic                             memToRegE,
	input  logic                             memToRegM,
	input  logic                             branchD,
	input  logic                             jumpD,
	input  logic                             pcSrcD,
	output logic [1:0]                       forwardAD,
	output logic [1:0]                       forwardBD,
	output logic [1:0]                       forwardAE,
	output logic [1:0]                       forwardBE,
	output logic                             stallF,
	output logic                             stallD,
	output logic                             flushD,
	output logic                             flushE
);
	logic lwStall, branchStall;

	// memory stage has priority, it is the younger result
	function automatic logic [1:0] fwdSel(
		input logic [mipsPkg::regAddrWidth-1:0] src,
		input logic [mipsPkg::regAddrWidth-1:0] wrM,
		input logic [mipsPkg::regAddrWidth-1:0] wrW,
		input logic                             weM,
		input logic                             weW
	);
		if (src != '0 && weM && src == wrM)
			return 2'b10;
		if (src != '0 && weW && src == wrW)
			return 2'b01;
		return 2'b00;
	endfunction

	assign forwardAD = fwdSel(rsD, writeRegM, writeRegW, regWriteM, regWriteW);
	assign forwardBD = fwdSel(rtD, writeRegM, writeRegW, regWriteM, regWriteW);
	assign forwardAE = fwdSel(rsE, writeRegM, writeRegW, regWriteM, regWriteW);
	assign forwardBE = fwdSel(rtE, writeRegM, writeRegW, regWriteM, regWriteW);

	assign lwStall = memToRegE && (rtE == rsD || rtE == rtD); // load result not ready yet
	// beq waits for alu result in E (1 cycle) or load in E then M (2 cycles)
	assign branchStall = branchD &&
		((regWriteE && (writeRegE == rsD || writeRegE == rtD)) ||
		 (memToRegM && (writeRegM == rsD || writeRegM == rtD)));

	assign stallD = lwStall || branchStall;
	assign stallF = stallD;
	assign flushE = stallD;                          // bubble behind the held instruction
	assign flushD = (pcSrcD || jumpD) && !stallD;    // stale equalD ignored while stalled
endmodule

//--- datapath/datapath.sv
/* datapath
   five-stage MIPS datapath: pc, stage registers, forwarding and branch compare */
`timescale 1ns/1ps

module datapath (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic [mipsPkg::dataWidth-1:0]    instr,
	input  logic [mipsPkg::dataWidth-1:0]    readData,
	input  logic                             regWriteD,
	input  logic                             memToRegD,
	input  logic                             memWriteD,
	input  logic                             regDstD,
	input  logic                             aluSrcD,
	input  logic [2:0]                       aluControlD,
	input  logic                             pcSrcD,
	input  logic                             jumpD,
	input  logic                             stallF,
	input  logic                             stallD,
	input  logic                             flushD,
	input  logic                             flushE,
	input  logic [1:0]                       forwardAD,
	input  logic [1:0]                       forwardBD,
	input  logic [1:0]                       forwardAE,
	input  logic [1:0]                       forwardBE,
	output logic [mipsPkg::dataWidth-1:0]    pc,
	output logic [mipsPkg::dataWidth-1:0]    dataAddr,
	output logic [mipsPkg::dataWidth-1:0]    writeData,
	output logic                             memWrite,
	output logic [5:0]                       opD,
	output logic [5:0]                       functD,
	output logic                             equalD,
	output logic [mipsPkg::regAddrWidth-1:0] rsD,
	output logic [mipsPkg::regAddrWidth-1:0] rtD,
	output logic [mipsPkg::regAddrWidth-1:0] rsE,
	output logic [mipsPkg::regAddrWidth-1:0] rtE,
	output logic [mipsPkg::regAddrWidth-1:0] writeRegE,
	output logic [mipsPkg::regAddrWidth-1:0] writeRegM,
	output logic [mipsPkg::regAddrWidth-1:0] writeRegW,
	output logic                             regWriteE,
	output logic                             regWriteM,
	output logic                             regWriteW,
	output logic                             memToRegE,
	output logic                             memToRegM
);
	mipsPkg::ifIdT ifIdIn, ifId;
	mipsPkg::idExT idExIn, idEx;
	mipsPkg::exMemT exMemIn, exMem;
	mipsPkg::memWbT memWbIn, memWb;

	logic [mipsPkg::dataWidth-1:0] pcNext, pcPlus4F, pcBranchD, pcJumpD;
	logic [mipsPkg::dataWidth-1:0] rd1D, rd2D, signImmD, srcAD, srcBD;
	logic [mipsPkg::dataWidth-1:0] srcAE, srcBE, writeDataE, aluOutE, resultW;

	// 00 register value, 10 memory stage alu result, 01 writeback result
	function automatic logic [mipsPkg::dataWidth-1:0] fwd(
		input logic [1:0]                    sel,
		input logic [mipsPkg::dataWidth-1:0] regVal,
		input logic [mipsPkg::dataWidth-1:0] memVal,
		input logic [mipsPkg::dataWidth-1:0] wbVal
	);
		case (sel)
			2'b10: return memVal;
			2'b01: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// fetch
	assign pcPlus4F = pc + 32'd4;
	assign pcNext = jumpD ? pcJumpD : (pcSrcD ? pcBranchD : pcPlus4F);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (!stallF) begin
			pc <= pcNext;
		end
	end

	assign ifIdIn = '{instr: instr, pcPlus4: pcPlus4F};
	pipeReg #(.payloadT(mipsPkg::ifIdT)) uIfId (.clk(clk), .arstN(arstN), .en(!stallD),
		.clr(flushD), .d(ifIdIn), .q(ifId));

	// decode
	assign opD = ifId.instr[31:26];
	assign functD = ifId.instr[5:0];
	assign rsD = ifId.instr[25:21];
	assign rtD = ifId.instr[20:16];
	assign signImmD = {{16{ifId.instr[15]}}, ifId.instr[15:0]};
	assign pcBranchD = ifId.pcPlus4 + {signImmD[29:0], 2'b00};
	assign pcJumpD = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00}; // same 256MB region

	regFile uRegFile (.clk(clk), .arstN(arstN), .we(memWb.regWrite), .ra1(rsD), .ra2(rtD),
		.wa(memWb.writeReg), .wd(resultW), .rd1(rd1D), .rd2(rd2D));

	assign srcAD = fwd(forwardAD, rd1D, exMem.aluOut, resultW);
	assign srcBD = fwd(forwardBD, rd2D, exMem.aluOut, resultW);
	assign equalD = (srcAD == srcBD); // beq compare, early resolve

	assign idExIn = '{regWrite: regWriteD, memToReg: memToRegD, memWrite: memWriteD,
		aluSrc: aluSrcD, regDst: regDstD, aluControl: aluControlD,
		rd1: rd1D, rd2: rd2D, signImm: signImmD,
		rs: rsD, rt: rtD, rd: ifId.instr[15:11]};
	pipeReg #(.payloadT(mipsPkg::idExT)) uIdEx (.clk(clk), .arstN(arstN), .en(1'b1),
		.clr(flushE), .d(idExIn), .q(idEx));

	// execute
	assign rsE = idEx.rs;
	assign rtE = idEx.rt;
	assign regWriteE = idEx.regWrite;
	assign memToRegE = idEx.memToReg;
	assign writeRegE = idEx.regDst ? idEx.rd : idEx.rt; // rd for r-type
	assign srcAE = fwd(forwardAE, idEx.rd1, exMem.aluOut, resultW);
	assign writeDataE = fwd(forwardBE, idEx.rd2, exMem.aluOut, resultW);
	assign srcBE = idEx.aluSrc ? idEx.signImm : writeDataE;

	alu uAlu (.a(srcAE), .b(srcBE), .aluControl(idEx.aluControl), .result(aluOutE));

	assign exMemIn = '{regWrite: idEx.regWrite, memToReg: idEx.memToReg,
		memWrite: idEx.memWrite, aluOut: aluOutE, writeData: writeDataE, writeReg: writeRegE};
	pipeReg #(.payloadT(mipsPkg::exMemT)) uExMem (.clk(clk), .arstN(arstN), .en(1'b1),
		.clr(1'b0), .d(exMemIn), .q(exMem));

	// memory, data memory sits outside
	assign dataAddr = exMem.aluOut;
	assign writeData = exMem.writeData;
	assign memWrite = exMem.memWrite;
	assign regWriteM = exMem.regWrite;
	assign memToRegM = exMem.memToReg;
	assign writeRegM = exMem.writeReg;

	assign memWbIn = '{regWrite: exMem.regWrite, memToReg: exMem.memToReg,
		readData: readData, aluOut: exMem.aluOut, writeReg: exMem.writeReg};
	pipeReg #(.payloadT(mipsPkg::memWbT)) uMemWb (.clk(clk), .arstN(arstN), .en(1'b1),
		.clr(1'b0), .d(memWbIn), .q(memWb));

	// writeback
	assign regWriteW = memWb.regWrite;
	assign writeRegW = memWb.writeReg;
	assign resultW = memWb.memToReg ? memWb.readData : memWb.aluOut;
endmodule

//--- source/mipsPipe.sv
/* mipsPipe
   pipelined MIPS core top, memories reached through combinational ports */
`timescale 1ns/1ps

module mipsPipe (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic [mipsPkg::dataWidth-1:0] instr,     // imem data for pc
	input  logic [mipsPkg::dataWidth-1:0] readData,  // dmem data for dataAddr
	output logic [mipsPkg::dataWidth-1:0] pc,
	output logic [mipsPkg::dataWidth-1:0] dataAddr,
	output logic [mipsPkg::dataWidth-1:0] writeData,
	output logic                          memWrite
);
	logic [5:0] opD, functD;
	logic [2:0] aluControlD;
	logic equalD, branchD, pcSrcD, jumpD;
	logic regWriteD, memToRegD, memWriteD, regDstD, aluSrcD;
	logic stallF, stallD, flushD, flushE;
	logic [1:0] forwardAD, forwardBD, forwardAE, forwardBE;
	logic [mipsPkg::regAddrWidth-1:0] rsD, rtD, rsE, rtE;
	logic [mipsPkg::regAddrWidth-1:0] writeRegE, writeRegM, writeRegW;
	logic regWriteE, regWriteM, regWriteW, memToRegE, memToRegM;

	controller uController (.op(opD), .funct(functD), .equalD(equalD), .branchD(branchD),
		.pcSrcD(pcSrcD), .jumpD(jumpD), .regWriteD(regWriteD), .memToRegD(memToRegD),
		.memWriteD(memWriteD), .regDstD(regDstD), .aluSrcD(aluSrcD),
		.aluControlD(aluControlD));

	datapath uDatapath (.clk(clk), .arstN(arstN), .instr(instr), .readData(readData),
		.regWriteD(regWriteD), .memToRegD(memToRegD), .memWriteD(memWriteD),
		.regDstD(regDstD), .aluSrcD(aluSrcD), .aluControlD(aluControlD), .pcSrcD(pcSrcD),
		.jumpD(jumpD), .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
		.forwardAD(forwardAD), .forwardBD(forwardBD), .forwardAE(forwardAE),
		.forwardBE(forwardBE), .pc(pc), .dataAddr(dataAddr), .writeData(writeData),
		.memWrite(memWrite), .opD(opD), .functD(functD), .equalD(equalD), .rsD(rsD),
		.rtD(rtD), .rsE(rsE), .rtE(rtE), .writeRegE(writeRegE), .writeRegM(writeRegM),
		.writeRegW(writeRegW), .regWriteE(regWriteE), .regWriteM(regWriteM),
		.regWriteW(regWriteW), .memToRegE(memToRegE), .memToRegM(memToRegM));

	hazardUnit uHazardUnit (.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
		.memToRegE(memToRegE), .memToRegM(memToRegM), .branchD(branchD), .jumpD(jumpD),
		.pcSrcD(pcSrcD), .forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF), .stallD(stallD),
		.flushD(flushD), .flushE(flushE));
endmodule

//--- sim/mipsTb_chk.sv
/* mipsTb_chk
   concurrent checks on pc and the store strobe, bound into the core top */
`timescale 1ns/1ps

module mipsTb_chk (
	input logic        clk,
	input logic        arstN,
	input logic [31:0] pc,
	input logic        memWrite,
	input logic        stallF
);
	// store strobe resolved once out of reset
	memWriteKnown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(memWrite))
		else $error("memWrite is unknown");

	pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

	// fetch stall freezes pc for that edge
	pcHeld: assert property (@(posedge clk) disable iff (!arstN) stallF |=> $stable(pc))
		else $error("pc moved while fetch was stalled");

	noStoreInReset: assert property (@(posedge clk) !arstN |-> !memWrite)
		else $error("memWrite high during reset");
endmodule

bind mipsPipe mipsTb_chk uChk (.clk(clk), .arstN(arstN), .pc(pc), .memWrite(memWrite),
	.stallF(stallF));

//--- sim/mipsTb.sv
/* mipsTb
   directed tests for the pipelined MIPS core, with behavioral instruction and data memories */
`timescale 1ns/1ps

module mipsTb;
	logic clk, arstN;
	logic [31:0] instr, readData, pc, dataAddr, writeData;
	logic memWrite;
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] logAddr [$], logData [$]; // every store seen by dmem in order
	logic [31:0] expAddr [$], expData [$];
	logic [31:0] lfsr, endAddr;
	logic [15:0] immA, immB;
	int pIdx, errCount, checkCount, testCount;

	mipsPipe DUT (.clk(clk), .arstN(arstN), .instr(instr), .readData(readData), .pc(pc),
		.dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite));

	always #10 clk = ~clk; // 20 ns period

	assign instr = imem[pc[9:2]];          // combinational imem
	assign readData = dmem[dataAddr[9:2]]; // combinational dmem read

	// dmem write port on the rising edge
	always @(posedge clk) begin
		if (arstN && memWrite) begin
			dmem[dataAddr[9:2]] <= writeData;
			logAddr.push_back(dataAddr);
			logData.push_back(writeData);
		end
	end

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr); // one step per bit
			v = {v[14:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] rOp(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
		return {mipsPkg::opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iOp(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic newProgram();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {mipsPkg::opJ, 18'd0, i[7:0]}; // stray fetch spins on its own word
		end
		pIdx = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic put(input logic [31:0] word);
		imem[pIdx] = word;
		pIdx++;
	endtask

	task automatic putJump(input int target);
		put({mipsPkg::opJ, 26'(target)}); // word index with upper pc bits zero
	endtask

	task automatic putSelfLoop();
		endAddr = pIdx * 4;
		putJump(pIdx);
	endtask

	task automatic addStore(input logic [31:0] addr, input logic [31:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic resetDut();
		@(posedge clk);
		arstN <= 1'b0;
		@(negedge clk);
		check("pc", pc, 32'h0);
		check("memWrite", {31'd0, memWrite}, 32'h0);
		logAddr.delete();
		logData.delete();
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		check("pc", pc, 32'h0);                    // first edge after release still in reset
		check("memWrite", {31'd0, memWrite}, 32'h0);
		check("store count", logAddr.size(), 32'h0);
	endtask

	task automatic waitPc(input logic [31:0] addr, input int limit);
		int n;
		n = 0;
		while (pc !== addr && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (pc !== addr) begin
			errCount++;
			$display("timeout: pc did not reach %h within %0d cycles", addr, limit);
		end
	endtask

	task automatic runProgram();
		resetDut();
		waitPc(endAddr, 200);
		repeat (6) @(negedge clk); // drain the five stages behind the final loop
		check("store count", logAddr.size(), expAddr.size());
		for (int i = 0; i < expAddr.size() && i < logAddr.size(); i++) begin
			check("dataAddr", logAddr[i], expAddr[i]);
			check("writeData", logData[i], expData[i]);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		$display("test %0d %s: %0d errors", testCount, name, errCount - errBefore);
	endtask

	task automatic testReset();
		int e0;
		e0 = errCount;
		newProgram();
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd1, 16'h0055));
		put(iOp(mipsPkg::opSw, 5'd0, 5'd1, 16'h0040));
		putSelfLoop();
		addStore(32'h40, 32'h55);
		runProgram();
		reportTest("reset", e0);
	endtask

	// chained runs dependent ops back to back, otherwise nops space them out
	task automatic testArith(input bit chained);
		int e0;
		logic [5:0] fns [5];
		logic [31:0] a, b, want [5];
		e0 = errCount;
		fns = '{mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd, mipsPkg::fnOr, mipsPkg::fnSlt};
		a = {{16{immA[15]}}, immA};
		b = {{16{immB[15]}}, immB};
		want = '{a + b, a - b, a & b, a | b, {31'd0, $signed(a) < $signed(b)}};
		newProgram();
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd1, immA));
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd2, immB));
		if (!chained) begin
			repeat (3) begin
				put(32'h0);
			end
			for (int k = 0; k < 5; k++) begin
				put(rOp(5'd1, 5'd2, 5'(3 + k), fns[k]));
			end
			repeat (3) begin
				put(32'h0);
			end
			for (int k = 0; k < 5; k++) begin
				put(iOp(mipsPkg::opSw, 5'd0, 5'(3 + k), 16'(k * 4)));
			end
		end else begin
			for (int k = 0; k < 5; k++) begin
				put(rOp(5'd1, 5'd2, 5'(3 + k), fns[k]));                 // first one forwards
				put(iOp(mipsPkg::opSw, 5'd0, 5'(3 + k), 16'(k * 4))); // store data from mem
			end
		end
		putSelfLoop();
		for (int k = 0; k < 5; k++) begin
			addStore(k * 4, want[k]);
		end
		runProgram();
		reportTest(chained ? "forwarding" : "arithmetic", e0);
	endtask

	task automatic testLoadUse();
		int e0;
		e0 = errCount;
		newProgram();
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd1, 16'h8421)); // negative word
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd2, 16'h0777));
		put(iOp(mipsPkg::opSw, 5'd0, 5'd1, 16'h0020));
		put(iOp(mipsPkg::opLw, 5'd0, 5'd3, 16'h0020));
		put(rOp(5'd3, 5'd2, 5'd4, mipsPkg::fnAdd));     // needs the load right away
		put(iOp(mipsPkg::opSw, 5'd0, 5'd4, 16'h0024));
		putSelfLoop();
		addStore(32'h20, 32'hffff8421);
		addStore(32'h24, 32'hffff8421 + 32'h0777);
		runProgram();
		reportTest("load-use", e0);
	endtask

	task automatic testBranch();
		int e0;
		e0 = errCount;
		newProgram();
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5));
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd2, 16'd5));
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd3, 16'd7));
		put(iOp(mipsPkg::opBeq, 5'd1, 5'd2, 16'd1));     // word 3 taken to word 5
		put(iOp(mipsPkg::opSw, 5'd0, 5'd3, 16'h0080));   // skipped
		put(iOp(mipsPkg::opSw, 5'd0, 5'd1, 16'h0084));
		put(iOp(mipsPkg::opBeq, 5'd1, 5'd3, 16'd1));     // word 6 not taken
		put(iOp(mipsPkg::opSw, 5'd0, 5'd3, 16'h0088));
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd4, 16'd5));
		put(iOp(mipsPkg::opBeq, 5'd4, 5'd1, 16'd1));     // word 9 waits on addi then goes to 11
		put(iOp(mipsPkg::opSw, 5'd0, 5'd3, 16'h008c));   // skipped
		putJump(13);
		put(iOp(mipsPkg::opSw, 5'd0, 5'd3, 16'h0090));   // skipped
		put(iOp(mipsPkg::opSw, 5'd0, 5'd2, 16'h0094));
		putSelfLoop();
		addStore(32'h84, 32'd5);
		addStore(32'h88, 32'd7);
		addStore(32'h94, 32'd5);
		runProgram();
		reportTest("control flow", e0);
	endtask

	task automatic testUnknownOp();
		int e0;
		e0 = errCount;
		newProgram();
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd1, 16'h0011));
		put(iOp(mipsPkg::opAddi, 5'd0, 5'd2, 16'h0022));
		put(iOp(6'h3f, 5'd1, 5'd2, 16'h1234));             // would clobber $2 if decoded
		put(iOp(mipsPkg::opSw, 5'd0, 5'd1, 16'h0040));
		put(iOp(mipsPkg::opSw, 5'd0, 5'd2, 16'h0044));
		put(iOp(6'h3f, 5'd0, 5'd1, 16'h0999));
		put(iOp(mipsPkg::opSw, 5'd0, 5'd1, 16'h0048));
		putSelfLoop();
		addStore(32'h40, 32'h11);
		addStore(32'h44, 32'h22);
		addStore(32'h48, 32'h11);
		runProgram();
		reportTest("unknown opcode", e0);
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		lfsr = 32'hcc18720c;
		errCount = 0;
		checkCount = 0;
		testCount = 0;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = 32'hd0d00000 + i; // background data tagged by address
		end
		newProgram();
		takeBits(16, immA);
		takeBits(16, immB);
		testReset();
		testArith(1'b0);
		testArith(1'b1);
		testLoadUse();
		testBranch();
		testUnknownOp();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

//--- src.f
common/mipsPkg.sv
source/alu.sv
source/regFile.sv
source/pipeReg.sv
source/controller.sv
datapath/hazardUnit.sv
datapath/datapath.sv
source/mipsPipe.sv
sim/mipsTb_chk.sv
sim/mipsTb.sv

//--- Bender.yml
package:
  name: mipsPipe

sources:
  - common/mipsPkg.sv
  - source/alu.sv
  - source/regFile.sv
  - source/pipeReg.sv
  - source/controller.sv
  - datapath/hazardUnit.sv
  - datapath/datapath.sv
  - source/mipsPipe.sv
  - target: simulation
    files:
      - sim/mipsTb_chk.sv
      - sim/mipsTb.sv
